// ==== all.f ====
+incdir+src
src/fetch_pkg.sv
src/resolve_if.sv
src/branch_predictor.sv
src/pc_stage.sv
src/refill_timer.sv
src/flush_ctrl.sv
src/fetch_top.sv
tests/fetch_asserts.sv
tests/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module fetch_tb \
    -f all.f \
    -o fetch_sim

./obj_dir/fetch_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation log is in sim.log"

// ==== src/branch_predictor.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module branch_predictor (
    input  wire              CLK,
    input  wire              arst_n,
    input  fetch_pkg::addr_t lookup_pc,
    output logic             hit,
    output fetch_pkg::addr_t target,
    resolve_if.learner       res
);
    import fetch_pkg::*;

    localparam int IDX_W   = `BTB_INDEX_BITS;
    localparam int ENTRIES = 1 << IDX_W;
    // Word aligned, so bits 1:0 are not stored
    localparam int TAG_W   = 30 - IDX_W;

    ////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////

    logic [ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]   tag_q [ENTRIES];
    addr_t              target_q [ENTRIES];

    logic [IDX_W-1:0]   lookup_idx;
    logic [TAG_W-1:0]   lookup_tag;
    logic [IDX_W-1:0]   update_idx;
    logic [TAG_W-1:0]   update_tag;

    assign lookup_idx = lookup_pc[IDX_W+1:2];
    assign lookup_tag = lookup_pc[31:IDX_W+2];
    assign update_idx = res.src_pc[IDX_W+1:2];
    assign update_tag = res.src_pc[31:IDX_W+2];

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    always_comb
    begin
        hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
        target = target_q[lookup_idx];
    end

    ////////////////////////////////////////
    // Update on every resolved transfer
    ////////////////////////////////////////

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_q <= '0;
        end
        else if (res.taken)
        begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    // Overwrite, no replacement choice in a direct-mapped table
    always_ff @(posedge CLK)
    begin
        if (res.taken)
        begin
            tag_q[update_idx]    <= update_tag;
            target_q[update_idx] <= res.target;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

////////////////////////////////////////
// Fetch front end parameters
////////////////////////////////////////

// First fetch address out of reset
`define FETCH_RESET_VECTOR 32'h0000_0100

// BTB holds 2**BTB_INDEX_BITS entries
`define BTB_INDEX_BITS 4

// Instruction memory refill cycles after the clear cycle, 1 or more
`define REFILL_CYCLES 3

`endif

// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Byte address or data word
    typedef logic [31:0] addr_t;

    // Execute stage operation codes
    typedef enum logic [4:0] {
        OP_ADD  = 5'b00000,
        OP_SUB  = 5'b00001,
        OP_AND  = 5'b00010,
        OP_OR   = 5'b00011,
        OP_XOR  = 5'b00100,
        OP_SLL  = 5'b00101,
        OP_SRL  = 5'b00110,
        OP_SRA  = 5'b00111,
        OP_SLT  = 5'b01000,
        OP_SLTU = 5'b01001,
        OP_JAL  = 5'b01010,
        OP_JALR = 5'b01011
    } exec_op_t;

    // Flush sequencing
    typedef enum logic [1:0] {
        FS_RUN,
        FS_CLEAR,
        FS_REFILL
    } flush_state_t;

endpackage

`default_nettype wire

// ==== src/fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  wire                 CLK,
    input  wire                 arst_n,
    input  wire                 stall,
    input  fetch_pkg::exec_op_t exec_op,
    input  wire                 branch_taken,
    input  fetch_pkg::addr_t    exec_pc,
    input  fetch_pkg::addr_t    rs1_data,
    input  fetch_pkg::addr_t    imm,
    input  fetch_pkg::addr_t    decode_pc,
    output fetch_pkg::addr_t    pc,
    output logic                clear_decode,
    output logic                clear_execute,
    output logic                fetch_valid
);
    import fetch_pkg::*;

    // BTB prediction for the current PC
    logic  predict_hit;
    addr_t predict_target;

    resolve_if u_res ();

    ////////////////////////////////////////
    // PC stage and predictor
    ////////////////////////////////////////

    pc_stage u_pc_stage (
        .CLK            (CLK),
        .arst_n         (arst_n),
        .stall          (stall),
        .exec_op        (exec_op),
        .branch_taken   (branch_taken),
        .exec_pc        (exec_pc),
        .rs1_data       (rs1_data),
        .imm            (imm),
        .decode_pc      (decode_pc),
        .predict_hit    (predict_hit),
        .predict_target (predict_target),
        .pc             (pc),
        .res            (u_res.source)
    );

    branch_predictor u_branch_predictor (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .lookup_pc (pc),
        .hit       (predict_hit),
        .target    (predict_target),
        .res       (u_res.learner)
    );

    ////////////////////////////////////////
    // Pipeline flush
    ////////////////////////////////////////

    flush_ctrl u_flush_ctrl (
        .CLK           (CLK),
        .arst_n        (arst_n),
        .clear_decode  (clear_decode),
        .clear_execute (clear_execute),
        .fetch_valid   (fetch_valid),
        .res           (u_res.flusher)
    );

endmodule

`default_nettype wire

// ==== src/flush_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module flush_ctrl (
    input  wire         CLK,
    input  wire         arst_n,
    output logic        clear_decode,
    output logic        clear_execute,
    output logic        fetch_valid,
    resolve_if.flusher  res
);
    import fetch_pkg::*;

    flush_state_t state;
    flush_state_t state_next;
    logic         refill_done;

    // Timer runs from the redirect edge, so the clear cycle counts toward the refill
    refill_timer #(
        .CYCLES (`REFILL_CYCLES)
    ) u_refill_timer (
        .CLK    (CLK),
        .arst_n (arst_n),
        .start  (res.redirect),
        .done   (refill_done)
    );

    ////////////////////////////////////////
    // Flush sequencing FSM
    ////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        if (res.redirect)
        begin
            // Any redirect restarts the sequence
            state_next = FS_CLEAR;
        end
        else
        begin
            case (state)
                FS_CLEAR  : state_next = FS_REFILL;
                FS_REFILL : state_next = refill_done ? FS_RUN : FS_REFILL;
                default   : state_next = FS_RUN;
            endcase
        end
    end

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= FS_RUN;
        end
        else
        begin
            state <= state_next;
        end
    end

    // Outputs come straight from the state register
    assign clear_decode  = (state == FS_CLEAR);
    assign clear_execute = (state == FS_CLEAR);
    assign fetch_valid   = (state == FS_RUN);

endmodule

`default_nettype wire

// ==== src/pc_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module pc_stage (
    input  wire                   CLK,
    input  wire                   arst_n,
    input  wire                   stall,
    input  fetch_pkg::exec_op_t   exec_op,
    input  wire                   branch_taken,
    input  fetch_pkg::addr_t      exec_pc,
    input  fetch_pkg::addr_t      rs1_data,
    input  fetch_pkg::addr_t      imm,
    input  fetch_pkg::addr_t      decode_pc,
    input  wire                   predict_hit,
    input  fetch_pkg::addr_t      predict_target,
    output fetch_pkg::addr_t      pc,
    resolve_if.source             res
);
    import fetch_pkg::*;

    logic  is_jal;
    logic  is_jalr;
    logic  xfer_taken;
    logic  wrong_path;
    addr_t target_base;
    addr_t resolved_target;
    addr_t next_pc;

    ////////////////////////////////////////
    // Resolve the transfer in execute
    ////////////////////////////////////////

    always_comb
    begin
        is_jal     = (exec_op == OP_JAL);
        is_jalr    = (exec_op == OP_JALR);
        xfer_taken = is_jal || is_jalr || branch_taken;
    end

    // JALR is register relative, JAL and branches are PC relative
    assign target_base     = is_jalr ? rs1_data : exec_pc;
    assign resolved_target = addr_t'($signed(target_base) + $signed(imm));

    // Decode holds the instruction fetched after the transfer
    assign wrong_path = xfer_taken && (resolved_target != decode_pc);

    assign res.taken    = xfer_taken;
    assign res.src_pc   = exec_pc;
    assign res.target   = resolved_target;
    assign res.redirect = wrong_path && !stall;

    ////////////////////////////////////////
    // Next PC and PC register
    ////////////////////////////////////////

    always_comb
    begin
        if (res.redirect)
        begin
            next_pc = resolved_target;
        end
        else if (predict_hit)
        begin
            next_pc = predict_target;
        end
        else
        begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= `FETCH_RESET_VECTOR;
        end
        else if (!stall)
        begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/refill_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module refill_timer #(
    parameter int CYCLES = `REFILL_CYCLES
) (
    input  wire  CLK,
    input  wire  arst_n,
    input  wire  start,
    output logic done
);

    localparam int CNT_W = $clog2(CYCLES + 1);

    logic [CNT_W-1:0] count_q;

    // Load on start, then count down to zero and rest there
    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count_q <= '0;
        end
        else if (start)
        begin
            count_q <= CNT_W'(CYCLES);
        end
        else if (count_q != '0)
        begin
            count_q <= count_q - 1'b1;
        end
    end

    assign done = (count_q == '0);

endmodule

`default_nettype wire

// ==== src/resolve_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One control transfer resolved in execute
interface resolve_if;
    import fetch_pkg::*;

    logic  taken;
    addr_t src_pc;
    addr_t target;
    logic  redirect;

    // PC stage resolves the transfer
    modport source (
        output taken,
        output src_pc,
        output target,
        output redirect
    );

    // BTB update side
    modport learner (
        input taken,
        input src_pc,
        input target
    );

    // Flush sequencing only needs the redirect
    modport flusher (
        input redirect
    );

endinterface

`default_nettype wire

// ==== tests/fetch_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_asserts (
    input wire                     CLK,
    input wire                     arst_n,
    input fetch_pkg::flush_state_t state,
    input wire                     clear_decode,
    input wire                     clear_execute,
    input wire                     fetch_valid
);
    import fetch_pkg::*;

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Stage clears are a single-cycle pulse
    clear_one_cycle: assert property (@(posedge CLK) disable iff (!arst_n)
        (clear_decode || clear_execute) |=> !(clear_decode || clear_execute))
    else
    begin
        fail_count++;
        $error("Stage clear held high for more than one cycle");
    end

    // Fetch resumes only after the clear cycle and the full refill
    refill_length: assert property (@(posedge CLK) disable iff (!arst_n)
        $rose(fetch_valid) |-> $past(clear_decode, `REFILL_CYCLES + 1))
    else
    begin
        fail_count++;
        $error("fetch_valid returned high at the wrong time after a clear");
    end

    clear_then_refill: assert property (@(posedge CLK) disable iff (!arst_n)
        (state == FS_CLEAR) |=> (state == FS_REFILL))
    else
    begin
        fail_count++;
        $error("Clear state not followed by refill state");
    end

endmodule

bind flush_ctrl fetch_asserts u_asserts (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .state         (state),
    .clear_decode  (clear_decode),
    .clear_execute (clear_execute),
    .fetch_valid   (fetch_valid)
);

`default_nettype wire

// ==== tests/fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int MAX_CYCLES  = 400;
    localparam int IDX_BITS    = `BTB_INDEX_BITS;
    localparam int BTB_ENTRIES = 1 << IDX_BITS;
    localparam int REFILL      = `REFILL_CYCLES;

    logic     CLK;
    logic     arst_n;
    logic     stall;
    exec_op_t exec_op;
    logic     branch_taken;
    addr_t    exec_pc;
    addr_t    rs1_data;
    addr_t    imm;
    addr_t    decode_pc;
    addr_t    pc;
    logic     clear_decode;
    logic     clear_execute;
    logic     fetch_valid;

    int    errors = 0;
    int    checks = 0;
    addr_t lcg_state = 32'h41f31419;

    // Reference model state
    addr_t              model_pc;
    logic [BTB_ENTRIES-1:0] model_valid;
    addr_t              model_tag [BTB_ENTRIES];
    addr_t              model_target [BTB_ENTRIES];
    int                 model_invalid_left;
    logic               model_clear;

    fetch_top u_dut (
        .CLK           (CLK),
        .arst_n        (arst_n),
        .stall         (stall),
        .exec_op       (exec_op),
        .branch_taken  (branch_taken),
        .exec_pc       (exec_pc),
        .rs1_data      (rs1_data),
        .imm           (imm),
        .decode_pc     (decode_pc),
        .pc            (pc),
        .clear_decode  (clear_decode),
        .clear_execute (clear_execute),
        .fetch_valid   (fetch_valid)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial
    begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic addr_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Word aligned, magnitude 1 KB to 2 KB
    function automatic addr_t random_offset();
        addr_t r;
        addr_t off;
        r = lcg_next();
        off = {22'd0, r[9:2], 2'b00} + 32'h0000_0400;
        if (r[31])
        begin
            off = -off;
        end
        return off;
    endfunction

    function automatic addr_t random_base();
        addr_t r;
        r = lcg_next();
        return {16'h0001, r[15:2], 2'b00};
    endfunction

    function automatic int btb_index(input addr_t a);
        return int'((a >> 2) & addr_t'(BTB_ENTRIES - 1));
    endfunction

    function automatic addr_t btb_tag(input addr_t a);
        return a >> (IDX_BITS + 2);
    endfunction

    task automatic check_equal(input string what, input addr_t got, input addr_t expected);
        checks++;
        assert (got === expected)
        else
        begin
            errors++;
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic drive_idle();
        stall        = 1'b0;
        exec_op      = OP_ADD;
        branch_taken = 1'b0;
        exec_pc      = '0;
        rs1_data     = '0;
        imm          = '0;
        decode_pc    = '0;
    endtask

    task automatic model_reset();
        model_pc           = `FETCH_RESET_VECTOR;
        model_valid        = '0;
        model_invalid_left = 0;
        model_clear        = 1'b0;
    endtask

    // Advance the model one edge from the driven inputs, then compare
    task automatic tick();
        logic  taken;
        logic  redirect;
        addr_t base;
        addr_t target;
        addr_t next_pc;
        int    idx;
        int    src_idx;
        taken    = (exec_op == OP_JAL) || (exec_op == OP_JALR) || branch_taken;
        base     = (exec_op == OP_JALR) ? rs1_data : exec_pc;
        target   = base + imm;
        redirect = taken && (target != decode_pc) && !stall;
        idx      = btb_index(model_pc);
        if (stall)
            next_pc = model_pc;
        else if (redirect)
            next_pc = target;
        else if (model_valid[idx] && (model_tag[idx] == btb_tag(model_pc)))
            next_pc = model_target[idx];
        else
            next_pc = model_pc + 32'd4;
        if (taken)
        begin
            src_idx = btb_index(exec_pc);
            model_valid[src_idx]  = 1'b1;
            model_tag[src_idx]    = btb_tag(exec_pc);
            model_target[src_idx] = target;
        end
        model_clear = redirect;
        if (redirect)
            model_invalid_left = REFILL + 1;
        else if (model_invalid_left > 0)
            model_invalid_left--;
        model_pc = next_pc;
        @(posedge CLK);
        @(negedge CLK);
        check_equal("pc", pc, model_pc);
        check_equal("clear_decode", 32'(clear_decode), 32'(model_clear));
        check_equal("clear_execute", 32'(clear_execute), 32'(model_clear));
        check_equal("fetch_valid", 32'(fetch_valid), 32'(model_invalid_left == 0));
    endtask

    // Count the cycles with fetch blocked, starting in a blocked cycle
    task automatic measure_refill(output int low_cycles);
        low_cycles = 0;
        while (!fetch_valid && low_cycles < 32)
        begin
            low_cycles++;
            tick();
        end
    endtask

    task automatic wait_fetch_valid();
        int n;
        n = 0;
        while (!fetch_valid && n < 32)
        begin
            n++;
            tick();
        end
        assert (fetch_valid)
        else
        begin
            errors++;
            $display("fetch_valid never returned high after a flush");
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_and_sequential();
        check_equal("reset pc", pc, `FETCH_RESET_VECTOR);
        check_equal("reset clear_decode", 32'(clear_decode), 32'd0);
        check_equal("reset fetch_valid", 32'(fetch_valid), 32'd1);
        repeat (5) tick();
    endtask

    task automatic test_stall();
        addr_t held;
        held  = pc;
        stall = 1'b1;
        repeat (3) tick();
        exec_op   = OP_JAL;
        exec_pc   = 32'h0000_8000;
        imm       = random_offset();
        decode_pc = 32'h0000_8004;
        tick();
        check_equal("pc under stall", pc, held);
        check_equal("clear under stall", 32'(clear_decode), 32'd0);
        drive_idle();
        tick();
    endtask

    task automatic test_jal_redirect();
        addr_t src;
        addr_t off;
        int    low_cycles;
        src = 32'h0000_2000;
        off = random_offset();
        exec_op   = OP_JAL;
        exec_pc   = src;
        imm       = off;
        decode_pc = src + off + 32'd4;
        tick();
        check_equal("jal target", pc, src + off);
        check_equal("jal clear_execute", 32'(clear_execute), 32'd1);
        drive_idle();
        measure_refill(low_cycles);
        check_equal("jal refill length", addr_t'(low_cycles), addr_t'(REFILL + 1));
    endtask

    task automatic test_jalr_and_branch();
        exec_op   = OP_JALR;
        exec_pc   = 32'h0000_3000;
        rs1_data  = random_base();
        imm       = random_offset();
        decode_pc = rs1_data + imm;
        tick();
        check_equal("jalr clear", 32'(clear_decode), 32'd0);
        drive_idle();
        branch_taken = 1'b1;
        exec_pc      = 32'h0000_3400;
        imm          = random_offset();
        decode_pc    = exec_pc + imm;
        tick();
        check_equal("branch clear", 32'(clear_decode), 32'd0);
        drive_idle();
        tick();
    endtask

    task automatic test_btb_learn();
        addr_t a_addr;
        addr_t b_addr;
        addr_t off_a;
        addr_t off_b;
        int    steps;
        a_addr = model_pc + 32'd32;
        b_addr = a_addr + (32'd1 << (IDX_BITS + 2));
        off_a  = random_offset();
        off_b  = random_offset();
        // Learn A without a redirect
        exec_op   = OP_JAL;
        exec_pc   = a_addr;
        imm       = off_a;
        decode_pc = a_addr + off_a;
        tick();
        drive_idle();
        steps = 0;
        while (pc != a_addr && steps < 16)
        begin
            steps++;
            tick();
        end
        assert (pc == a_addr)
        else
        begin
            errors++;
            $display("Fetch never reached the learned branch address");
        end
        tick();
        check_equal("predicted target", pc, a_addr + off_a);
        check_equal("prediction clear", 32'(clear_decode), 32'd0);
        // Same index, new tag and target
        exec_op   = OP_JAL;
        exec_pc   = b_addr;
        imm       = off_b;
        decode_pc = b_addr + off_b;
        tick();
        // Jump to B from a different index
        exec_pc   = b_addr + 32'd4;
        imm       = -32'd4;
        decode_pc = b_addr + 32'd8;
        tick();
        check_equal("redirect to b", pc, b_addr);
        drive_idle();
        tick();
        check_equal("overwritten prediction", pc, b_addr + off_b);
        wait_fetch_valid();
    endtask

    task automatic test_redirect_restart();
        int low_cycles;
        exec_op   = OP_JAL;
        exec_pc   = 32'h0000_4000;
        imm       = random_offset();
        decode_pc = 32'h0000_4004;
        tick();
        drive_idle();
        tick();
        // Now in refill
        exec_op   = OP_JAL;
        exec_pc   = 32'h0000_5000;
        imm       = random_offset();
        decode_pc = 32'h0000_5004;
        tick();
        check_equal("restart clear_decode", 32'(clear_decode), 32'd1);
        drive_idle();
        measure_refill(low_cycles);
        check_equal("restart refill length", addr_t'(low_cycles), addr_t'(REFILL + 1));
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        int assert_errors;
        arst_n = 1'b0;
        drive_idle();
        model_reset();
        repeat (8) @(negedge CLK);
        arst_n = 1'b1;

        test_reset_and_sequential();
        test_stall();
        test_jal_redirect();
        wait_fetch_valid();
        test_jalr_and_branch();
        test_btb_learn();
        test_redirect_restart();
        wait_fetch_valid();

        assert_errors = u_dut.u_flush_ctrl.u_asserts.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
